//--- sms_loader_defs.svh
// Divider period, download widths, header size, backup sector and index macros
`ifndef SMS_LOADER_DEFS_SVH
`define SMS_LOADER_DEFS_SVH

// ==========================================================================
// Clock enable divider
// ==========================================================================

// Length of one enable pattern in clk_sys cycles
`define SMS_CE_PERIOD 30

// ==========================================================================
// Cartridge download
// ==========================================================================

// CPU side ROM address width
`define SMS_ROM_AW 22
// Host download address width
`define SMS_IOCTL_AW 25
// Copier header in front of some images
`define SMS_HEADER_BYTES 512

// Index of cheat data downloads
`define SMS_CODE_INDEX 8'hFF
// Low index bits of a Game Gear image
`define SMS_GG_INDEX 5'd2

// ==========================================================================
// Backup RAM
// ==========================================================================

// 64 sectors of 512 bytes cover the 32K backup RAM
`define SMS_BK_SECTORS 64
`define SMS_LBA_W 6

`endif

//--- sms_load_pkg.sv
// Download index type and decode functions, cheat code field, byte and union types
`default_nettype none
`include "sms_loader_defs.svh"

package sms_load_pkg;

	// ======================================================================
	// Download index
	// ======================================================================

	typedef logic [7:0] dl_index_t;

	// Cheat data rides on the all-ones index
	function automatic logic is_code_index(input dl_index_t idx);
		return idx == `SMS_CODE_INDEX;
	endfunction

	// Only the low five bits select the image type
	function automatic logic is_gg_index(input dl_index_t idx);
		return idx[4:0] == `SMS_GG_INDEX;
	endfunction

	// ======================================================================
	// Cheat code word
	// ======================================================================

	// Flags on top, replace value at the bottom
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// Outer index picks the field, inner index the byte, low byte first
	// so download offset i lands on [i/4][i%4]
	typedef logic [0:3][3:0][7:0] cheat_bytes_t;

	typedef union packed {
		cheat_fields_t fields;
		cheat_bytes_t  bytes;
	} cheat_code_u;

endpackage

`default_nettype wire

//--- sms_backup_pkg.sv
// Backup RAM sequencer state type
`default_nettype none

package sms_backup_pkg;

	// Sector walk of the backup RAM transfer
	typedef enum logic [1:0] {
		// No transfer running
		BK_IDLE,
		// Read or write request raised, waiting for the SD ack
		BK_REQUEST,
		// Sector moving, waiting for the ack to drop
		BK_TRANSFER,
		// Advance the sector or finish
		BK_NEXT
	} bk_state_t;

endpackage

`default_nettype wire

//--- clock_enables.sv
// Clock enable divider producing CPU, VDP, pixel and sprite enables
`timescale 1ns/1ps
`default_nettype none
`include "sms_loader_defs.svh"

module clock_enables (
	input  wire  clk_sys,
	input  wire  reset,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);

	localparam logic [4:0] LAST_POS = 5'(`SMS_CE_PERIOD - 1);

	logic [4:0] clk_div;

	// ======================================================================
	// One pattern of 30 cycles
	// VDP every 5, pixel every 10, CPU twice, sprites every other cycle
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clk_div <= '0;
			ce_cpu  <= 1'b0;
			ce_vdp  <= 1'b0;
			ce_pix  <= 1'b0;
			ce_sp   <= 1'b0;
		end else begin
			ce_sp  <= clk_div[0];
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;

			if (clk_div == LAST_POS)
				clk_div <= '0;
			else
				clk_div <= clk_div + 5'd1;

			case (clk_div)
				5'd4, 5'd14: begin
					ce_vdp <= 1'b1;
				end
				5'd9: begin
					ce_cpu <= 1'b1;
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
				end
				5'd19, LAST_POS: begin
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
				end
				// CPU phase shifted off the pixel slot here
				5'd24: begin
					ce_cpu <= 1'b1;
					ce_vdp <= 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- cart_download.sv
// Cartridge ROM write handshake, size masks, header detect and ROM address mapping
`timescale 1ns/1ps
`default_nettype none
`include "sms_loader_defs.svh"

module cart_download
	import sms_load_pkg::*;
(
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     ioctl_download,
	input  wire dl_index_t          ioctl_index,
	input  wire                     ioctl_wr,
	input  wire [`SMS_IOCTL_AW-1:0] ioctl_addr,
	input  wire [7:0]               ioctl_dout,
	input  wire                     rom_ack,
	input  wire [`SMS_ROM_AW-1:0]   rom_raddr_in,
	output logic                    cart_download,
	output logic                    ioctl_wait,
	output logic                    rom_wr,
	output logic [`SMS_ROM_AW-1:0]  rom_waddr,
	output logic [7:0]              rom_wdata,
	output logic [`SMS_ROM_AW-1:0]  rom_raddr,
	output logic                    gg_mode
);

	localparam int ROM_AW = `SMS_ROM_AW;
	localparam int IOCTL_AW = `SMS_IOCTL_AW;
	localparam int HDR_BIT = $clog2(`SMS_HEADER_BYTES);
	localparam logic [ROM_AW-1:0] HDR_SIZE = ROM_AW'(`SMS_HEADER_BYTES);

	logic              old_download;
	logic              cart_hdr;
	logic              cart_wr;
	logic [ROM_AW-1:0] cart_mask;
	logic [ROM_AW-1:0] cart_mask512;

	assign cart_download = ioctl_download & ~is_code_index(ioctl_index);
	assign cart_wr = ioctl_wr & cart_download;

	// ======================================================================
	// Write handshake toward ROM memory
	// ======================================================================
	// rom_wr toggles per byte, memory answers by matching rom_ack
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			ioctl_wait   <= 1'b0;
			rom_wr       <= 1'b0;
			rom_waddr    <= '0;
		end else begin
			old_download <= cart_download;
			if (cart_download & ~old_download) begin
				rom_waddr <= '0;
			end else if (cart_wr) begin
				ioctl_wait <= 1'b1;
				rom_wr     <= ~rom_wr;
			end else if (ioctl_wait && (rom_wr == rom_ack)) begin
				ioctl_wait <= 1'b0;
				rom_waddr  <= rom_waddr + ROM_AW'(1);
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_wr)
			rom_wdata <= ioctl_dout;
	end

	// ======================================================================
	// Size masks and image type
	// ======================================================================
	// Second mask assumes the image starts after the header
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			if (ioctl_addr == '0)
				cart_mask <= '0;
			else
				cart_mask <= cart_mask | ioctl_addr[ROM_AW-1:0];

			if (ioctl_addr == IOCTL_AW'(`SMS_HEADER_BYTES))
				cart_mask512 <= '0;
			else
				cart_mask512 <= cart_mask512 | (ioctl_addr[ROM_AW-1:0] - HDR_SIZE);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_hdr <= 1'b0;
			gg_mode  <= 1'b0;
		end else begin
			if (cart_wr)
				gg_mode <= is_gg_index(ioctl_index);
			// Byte count left on the address bus tells of a header
			if (old_download & ~cart_download)
				cart_hdr <= ioctl_addr[HDR_BIT];
		end
	end

	// CPU address into the downloaded image
	always_ff @(posedge clk_sys) begin
		if (cart_hdr)
			rom_raddr <= (rom_raddr_in + HDR_SIZE) & cart_mask512;
		else
			rom_raddr <= rom_raddr_in & cart_mask;
	end

endmodule

`default_nettype wire

//--- cheat_code_loader.sv
// Cheat code loader gathering 16 downloaded bytes into one code word
`timescale 1ns/1ps
`default_nettype none

module cheat_code_loader
	import sms_load_pkg::*;
(
	input  wire            clk_sys,
	input  wire            reset,
	input  wire            ioctl_download,
	input  wire dl_index_t ioctl_index,
	input  wire            ioctl_wr,
	input  wire [3:0]      ioctl_addr,
	input  wire [7:0]      ioctl_dout,
	output cheat_code_u    cheat_code,
	output logic           code_valid
);

	logic code_wr;
	logic last_byte;

	assign code_wr = ioctl_download & is_code_index(ioctl_index) & ioctl_wr;

	// Offset 15 closes the code
	assign last_byte = (ioctl_addr == 4'hF);

	// ======================================================================
	// Byte gathering
	// ======================================================================
	// Each field arrives low byte first, flags first
	always_ff @(posedge clk_sys) begin
		if (code_wr)
			cheat_code.bytes[ioctl_addr[3:2]][ioctl_addr[1:0]] <= ioctl_dout;
	end

	// Strobe with the completed word
	always_ff @(posedge clk_sys) begin
		if (reset)
			code_valid <= 1'b0;
		else
			code_valid <= code_wr & last_byte;
	end

endmodule

`default_nettype wire

//--- backup_sequencer.sv
// Backup RAM enable, pending flag and SD sector load and save sequencing
`timescale 1ns/1ps
`default_nettype none
`include "sms_loader_defs.svh"

module backup_sequencer
	import sms_backup_pkg::*;
(
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire                   cart_download,
	input  wire                   osd_open,
	input  wire                   autosave,
	input  wire                   bk_load_req,
	input  wire                   bk_save_req,
	input  wire                   img_mounted,
	input  wire                   img_readonly,
	input  wire                   img_size_nonzero,
	input  wire                   nvram_we,
	input  wire                   sd_ack,
	output logic                  sd_rd,
	output logic                  sd_wr,
	output logic [`SMS_LBA_W-1:0] sd_lba,
	output logic                  bk_busy,
	output logic                  bk_loading,
	output logic                  bk_pending
);

	localparam int LBA_W = `SMS_LBA_W;
	localparam logic [LBA_W-1:0] LAST_LBA = LBA_W'(`SMS_BK_SECTORS - 1);

	bk_state_t state;
	logic      old_cart;
	logic      bk_ena;
	logic      loading_q;
	logic      auto_load;
	logic      req_load;
	logic      req_save;
	logic      start;

	// ======================================================================
	// Enable and pending save
	// ======================================================================
	// Save image gets mounted while the cartridge is still downloading
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_cart   <= 1'b0;
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			old_cart <= cart_download;
			if (cart_download & ~old_cart)
				bk_ena <= 1'b0;
			if (cart_download & img_mounted & ~img_readonly)
				bk_ena <= 1'b1;

			if (start)
				bk_pending <= 1'b0;
			else if (bk_ena & ~osd_open & nvram_we)
				bk_pending <= 1'b1;
		end
	end

	// Load after each cartridge, save when the menu opens with unsaved data
	assign auto_load = old_cart & ~cart_download & img_size_nonzero & bk_ena;
	assign req_load = (bk_ena & bk_load_req) | auto_load;
	assign req_save = bk_ena & (bk_save_req | (osd_open & autosave & bk_pending));
	assign start = (state == BK_IDLE) & (req_load | req_save);

	assign bk_busy = (state != BK_IDLE);
	// Covers the start cycle so system reset has no gap after a download
	assign bk_loading = loading_q | (start & req_load);

	// ======================================================================
	// Sector walk
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= BK_IDLE;
			loading_q <= 1'b0;
			sd_rd     <= 1'b0;
			sd_wr     <= 1'b0;
			sd_lba    <= '0;
		end else begin
			case (state)
				BK_IDLE: begin
					if (start) begin
						loading_q <= req_load;
						sd_lba    <= '0;
						sd_rd     <= req_load;
						sd_wr     <= ~req_load;
						state     <= BK_REQUEST;
					end
				end
				BK_REQUEST: begin
					if (sd_ack) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= BK_TRANSFER;
					end
				end
				BK_TRANSFER: begin
					if (~sd_ack)
						state <= BK_NEXT;
				end
				BK_NEXT: begin
					if (sd_lba == LAST_LBA) begin
						loading_q <= 1'b0;
						state     <= BK_IDLE;
					end else begin
						sd_lba <= sd_lba + LBA_W'(1);
						sd_rd  <= loading_q;
						sd_wr  <= ~loading_q;
						state  <= BK_REQUEST;
					end
				end
				default: begin
					state <= BK_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- sms_loader_top.sv
// Loader top level with clock enables, cartridge, cheat and backup blocks, reset and LED
`timescale 1ns/1ps
`default_nettype none
`include "sms_loader_defs.svh"

module sms_loader_top
	import sms_load_pkg::*;
(
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     ioctl_download,
	input  wire dl_index_t          ioctl_index,
	input  wire                     ioctl_wr,
	input  wire [`SMS_IOCTL_AW-1:0] ioctl_addr,
	input  wire [7:0]               ioctl_dout,
	input  wire                     rom_ack,
	input  wire [`SMS_ROM_AW-1:0]   rom_raddr_in,
	input  wire                     osd_open,
	input  wire                     autosave,
	input  wire                     bk_load_req,
	input  wire                     bk_save_req,
	input  wire                     img_mounted,
	input  wire                     img_readonly,
	input  wire                     img_size_nonzero,
	input  wire                     nvram_we,
	input  wire                     sd_ack,
	output logic                    ce_cpu,
	output logic                    ce_vdp,
	output logic                    ce_pix,
	output logic                    ce_sp,
	output logic                    ioctl_wait,
	output logic                    rom_wr,
	output logic [`SMS_ROM_AW-1:0]  rom_waddr,
	output logic [7:0]              rom_wdata,
	output logic [`SMS_ROM_AW-1:0]  rom_raddr,
	output logic                    gg_mode,
	output cheat_code_u             cheat_code,
	output logic                    code_valid,
	output logic                    sd_rd,
	output logic                    sd_wr,
	output logic [`SMS_LBA_W-1:0]   sd_lba,
	output logic                    system_reset,
	output logic                    led_user
);

	logic cart_download;
	logic bk_busy;
	logic bk_loading;
	logic bk_pending;

	// ======================================================================
	// Blocks
	// ======================================================================
	clock_enables i_clock_enables (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce_cpu  (ce_cpu),
		.ce_vdp  (ce_vdp),
		.ce_pix  (ce_pix),
		.ce_sp   (ce_sp)
	);

	cart_download i_cart_download (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.rom_ack        (rom_ack),
		.rom_raddr_in   (rom_raddr_in),
		.cart_download  (cart_download),
		.ioctl_wait     (ioctl_wait),
		.rom_wr         (rom_wr),
		.rom_waddr      (rom_waddr),
		.rom_wdata      (rom_wdata),
		.rom_raddr      (rom_raddr),
		.gg_mode        (gg_mode)
	);

	// Byte lane comes from the low address bits only
	cheat_code_loader i_cheat_code_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr[3:0]),
		.ioctl_dout     (ioctl_dout),
		.cheat_code     (cheat_code),
		.code_valid     (code_valid)
	);

	backup_sequencer i_backup_sequencer (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.cart_download    (cart_download),
		.osd_open         (osd_open),
		.autosave         (autosave),
		.bk_load_req      (bk_load_req),
		.bk_save_req      (bk_save_req),
		.img_mounted      (img_mounted),
		.img_readonly     (img_readonly),
		.img_size_nonzero (img_size_nonzero),
		.nvram_we         (nvram_we),
		.sd_ack           (sd_ack),
		.sd_rd            (sd_rd),
		.sd_wr            (sd_wr),
		.sd_lba           (sd_lba),
		.bk_busy          (bk_busy),
		.bk_loading       (bk_loading),
		.bk_pending       (bk_pending)
	);

	// Core held while ROM or backup RAM contents change
	assign system_reset = reset | cart_download | bk_loading;

	// Lit on any transfer, and while autosave data waits
	assign led_user = cart_download | bk_busy | (autosave & bk_pending);

endmodule

`default_nettype wire

//--- tb_sms_loader.sv
// Testbench for the loader top level with ROM and SD responders, checks and report
`timescale 1ns/1ps
`default_nettype none
`include "sms_loader_defs.svh"

module tb_sms_loader
	import sms_load_pkg::*;
();

	localparam int ROM_AW = `SMS_ROM_AW;
	localparam int IOCTL_AW = `SMS_IOCTL_AW;
	localparam int N_ROM = 8;
	localparam int CHEAT_BASE = 8;
	localparam int FIELD_BASE = 24;
	localparam int N_WORDS = 28;
	localparam int MAX_IMAGE = 'h4200;
	localparam int WAIT_LIMIT = 64;
	localparam int BK_LIMIT = 20000;
	localparam logic [ROM_AW-1:0] CART_MASK = ROM_AW'('h3FFF);

	logic                  clk_sys;
	logic                  reset;
	logic                  ioctl_download;
	logic [7:0]            ioctl_index;
	logic                  ioctl_wr;
	logic [IOCTL_AW-1:0]   ioctl_addr;
	logic [7:0]            ioctl_dout;
	logic                  rom_ack;
	logic [ROM_AW-1:0]     rom_raddr_in;
	logic                  osd_open;
	logic                  autosave;
	logic                  bk_load_req;
	logic                  bk_save_req;
	logic                  img_mounted;
	logic                  img_readonly;
	logic                  img_size_nonzero;
	logic                  nvram_we;
	logic                  sd_ack;

	logic                  ce_cpu;
	logic                  ce_vdp;
	logic                  ce_pix;
	logic                  ce_sp;
	logic                  ioctl_wait;
	logic                  rom_wr;
	logic [ROM_AW-1:0]     rom_waddr;
	logic [7:0]            rom_wdata;
	logic [ROM_AW-1:0]     rom_raddr;
	logic                  gg_mode;
	cheat_code_u           cheat_code;
	logic                  code_valid;
	logic                  sd_rd;
	logic                  sd_wr;
	logic [`SMS_LBA_W-1:0] sd_lba;
	logic                  system_reset;
	logic                  led_user;

	// Stimulus words and the bytes of the image being downloaded
	logic [31:0] patterns [0:N_WORDS-1];
	logic [7:0]  dl_bytes [0:MAX_IMAGE-1];
	integer      seed;
	string       cur_test;
	int          test_errs;
	int          tests_run;
	int          tests_failed;

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	sms_loader_top i_sms_loader_top (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.ioctl_download   (ioctl_download),
		.ioctl_index      (ioctl_index),
		.ioctl_wr         (ioctl_wr),
		.ioctl_addr       (ioctl_addr),
		.ioctl_dout       (ioctl_dout),
		.rom_ack          (rom_ack),
		.rom_raddr_in     (rom_raddr_in),
		.osd_open         (osd_open),
		.autosave         (autosave),
		.bk_load_req      (bk_load_req),
		.bk_save_req      (bk_save_req),
		.img_mounted      (img_mounted),
		.img_readonly     (img_readonly),
		.img_size_nonzero (img_size_nonzero),
		.nvram_we         (nvram_we),
		.sd_ack           (sd_ack),
		.ce_cpu           (ce_cpu),
		.ce_vdp           (ce_vdp),
		.ce_pix           (ce_pix),
		.ce_sp            (ce_sp),
		.ioctl_wait       (ioctl_wait),
		.rom_wr           (rom_wr),
		.rom_waddr        (rom_waddr),
		.rom_wdata        (rom_wdata),
		.rom_raddr        (rom_raddr),
		.gg_mode          (gg_mode),
		.cheat_code       (cheat_code),
		.code_valid       (code_valid),
		.sd_rd            (sd_rd),
		.sd_wr            (sd_wr),
		.sd_lba           (sd_lba),
		.system_reset     (system_reset),
		.led_user         (led_user)
	);

	// ======================================================================
	// Bookkeeping
	// ======================================================================
	task automatic start_test(input string name);
		cur_test = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errs == 0) begin
			$display("PASS %s", cur_test);
		end else begin
			tests_failed++;
			$display("FAIL %s with %0d errors", cur_test, test_errs);
		end
	endtask

	task automatic check_equal(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("ERR %s %s: expected 0x%0h, actual 0x%0h", cur_test, what,
				expected, actual);
			test_errs++;
		end
	endtask

	task automatic note_timeout(input int waited, input int limit, input string what);
		assert (waited < limit) else begin
			$display("%s timed out waiting for %s", cur_test, what);
			test_errs++;
		end
	endtask

	// ROM and SD response latency of 1 to 4 cycles
	function automatic int rand_delay();
		return 1 + int'($unsigned($random(seed)) % 32'd4);
	endfunction

	// ======================================================================
	// Cartridge download with the ROM memory answering each toggle
	// ======================================================================
	task automatic run_download(input logic [7:0] index, input int length);
		int a;
		int k;
		int n;
		int delay;
		@(negedge clk_sys);
		ioctl_index = index;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		for (a = 0; a < length; a++) begin
			ioctl_addr = IOCTL_AW'(a);
			ioctl_dout = dl_bytes[a];
			ioctl_wr = 1'b1;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			check_equal("ioctl_wait", 32'd1, 32'(ioctl_wait));
			check_equal("rom_wr toggle", 32'(!rom_ack), 32'(rom_wr));
			check_equal("rom_waddr", 32'(a), 32'(rom_waddr));
			check_equal("rom_wdata", 32'(dl_bytes[a]), 32'(rom_wdata));
			check_equal("system_reset", 32'd1, 32'(system_reset));
			delay = rand_delay();
			for (k = 0; k < delay; k++) begin
				@(negedge clk_sys);
				check_equal("ioctl_wait before ack", 32'd1, 32'(ioctl_wait));
			end
			rom_ack = rom_wr;
			n = 0;
			while (ioctl_wait && n < WAIT_LIMIT) begin
				@(negedge clk_sys);
				n++;
			end
			note_timeout(n, WAIT_LIMIT, "ioctl_wait to fall after the ROM ack");
		end
		// Host leaves the byte count on the address bus
		ioctl_addr = IOCTL_AW'(length);
		ioctl_download = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic check_raddr(input logic header);
		logic [ROM_AW-1:0] addr_in;
		logic [ROM_AW-1:0] expected;
		int i;
		for (i = 0; i < 8; i++) begin
			addr_in = ROM_AW'($unsigned($random(seed)));
			@(negedge clk_sys);
			rom_raddr_in = addr_in;
			@(negedge clk_sys);
			if (header)
				expected = (addr_in + ROM_AW'(`SMS_HEADER_BYTES)) & CART_MASK;
			else
				expected = addr_in & CART_MASK;
			check_equal("rom_raddr", 32'(expected), 32'(rom_raddr));
		end
	endtask

	// ======================================================================
	// SD side of a backup transfer, one ack per sector
	// ======================================================================
	task automatic serve_backup(input logic [1:0] op, input logic loading);
		int k;
		int n;
		int delay;
		int sectors;
		logic [1:0] stray;
		n = 0;
		sectors = 0;
		while (led_user && n < BK_LIMIT) begin
			stray = {sd_rd, sd_wr} & ~op;
			check_equal("other sd request", 32'd0, 32'(stray));
			if (loading)
				check_equal("system_reset during load", 32'd1, 32'(system_reset));
			if (sd_rd | sd_wr) begin
				check_equal("sd_lba", 32'(sectors), 32'(sd_lba));
				delay = rand_delay();
				for (k = 0; k < delay; k++) begin
					@(negedge clk_sys);
					check_equal("sd request before ack", 32'(op), 32'({sd_rd, sd_wr}));
				end
				sd_ack = 1'b1;
				@(negedge clk_sys);
				check_equal("sd request after ack", 32'd0, 32'({sd_rd, sd_wr}));
				delay = rand_delay();
				repeat (delay) @(negedge clk_sys);
				sd_ack = 1'b0;
				sectors++;
			end
			@(negedge clk_sys);
			n++;
		end
		note_timeout(n, BK_LIMIT, "the backup transfer to finish");
		check_equal("sectors", 32'(`SMS_BK_SECTORS), 32'(sectors));
		if (loading)
			check_equal("system_reset after load", 32'd0, 32'(system_reset));
	endtask

	// ======================================================================
	// Tests
	// ======================================================================
	task automatic test_clock_enables();
		logic [59:0] vdp_hist;
		logic [59:0] pix_hist;
		logic [59:0] cpu_hist;
		logic [59:0] sp_hist;
		int i;
		start_test("clock_enables");
		for (i = 0; i < 60; i++) begin
			@(negedge clk_sys);
			vdp_hist[i] = ce_vdp;
			pix_hist[i] = ce_pix;
			cpu_hist[i] = ce_cpu;
			sp_hist[i] = ce_sp;
			check_equal("ce_vdp with ce_cpu", 32'(ce_cpu), 32'(ce_cpu & ce_vdp));
		end
		// Every window of one period at any phase
		for (i = 0; i < `SMS_CE_PERIOD; i++) begin
			check_equal("ce_vdp count", 32'd6, 32'($countones(vdp_hist[i +: 30])));
			check_equal("ce_pix count", 32'd3, 32'($countones(pix_hist[i +: 30])));
			check_equal("ce_cpu count", 32'd2, 32'($countones(cpu_hist[i +: 30])));
			check_equal("ce_sp count", 32'd15, 32'($countones(sp_hist[i +: 30])));
		end
		end_test();
	endtask

	task automatic test_cheat_code();
		int a;
		start_test("cheat_code");
		@(negedge clk_sys);
		ioctl_index = `SMS_CODE_INDEX;
		ioctl_download = 1'b1;
		for (a = 0; a < 16; a++) begin
			@(negedge clk_sys);
			ioctl_addr = IOCTL_AW'(a);
			ioctl_dout = patterns[CHEAT_BASE + a][7:0];
			ioctl_wr = 1'b1;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			check_equal("code_valid", 32'(a == 15), 32'(code_valid));
			check_equal("ioctl_wait", 32'd0, 32'(ioctl_wait));
		end
		@(negedge clk_sys);
		check_equal("code_valid after pulse", 32'd0, 32'(code_valid));
		ioctl_download = 1'b0;
		check_equal("flags", patterns[FIELD_BASE], cheat_code.fields.flags);
		check_equal("address", patterns[FIELD_BASE + 1], cheat_code.fields.address);
		check_equal("compare", patterns[FIELD_BASE + 2], cheat_code.fields.compare);
		check_equal("replace", patterns[FIELD_BASE + 3], cheat_code.fields.replace);
		end_test();
	endtask

	initial begin
		int i;
		seed = 19229;
		tests_run = 0;
		tests_failed = 0;
		test_errs = 0;
		cur_test = "setup";
		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = 8'h00;
		rom_ack = 1'b0;
		rom_raddr_in = '0;
		osd_open = 1'b0;
		autosave = 1'b0;
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size_nonzero = 1'b0;
		nvram_we = 1'b0;
		sd_ack = 1'b0;
		for (i = 0; i < N_WORDS; i++)
			patterns[i] = '1;
		$readmemh("sms_loader_patterns.txt", patterns);

		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		start_test("reset_state");
		check_equal("ce outputs", 32'd0, 32'({ce_cpu, ce_vdp, ce_pix, ce_sp}));
		check_equal("ioctl_wait", 32'd0, 32'(ioctl_wait));
		check_equal("code_valid", 32'd0, 32'(code_valid));
		check_equal("sd requests", 32'd0, 32'({sd_rd, sd_wr}));
		check_equal("led_user", 32'd0, 32'(led_user));
		check_equal("system_reset", 32'd1, 32'(system_reset));
		end_test();
		reset = 1'b0;

		start_test("pattern_file");
		for (i = 0; i < FIELD_BASE; i++) begin
			assert (patterns[i][31:8] == 24'h0) else begin
				$display("Pattern file is missing or holds a bad byte at word %0d", i);
				test_errs++;
			end
		end
		assert (patterns[N_WORDS-1] != '1) else begin
			$display("Pattern file is missing the expected cheat fields");
			test_errs++;
		end
		end_test();

		test_clock_enables();

		start_test("cart_write");
		for (i = 0; i < N_ROM; i++)
			dl_bytes[i] = patterns[i][7:0];
		run_download(8'h00, N_ROM);
		check_equal("rom_waddr at end", 32'(N_ROM), 32'(rom_waddr));
		check_equal("system_reset after download", 32'd0, 32'(system_reset));
		end_test();

		start_test("rom_mapping");
		for (i = 0; i < MAX_IMAGE; i++)
			dl_bytes[i] = 8'(i) ^ 8'(i >> 8);
		run_download(8'h00, 'h4000);
		check_raddr(1'b0);
		check_equal("gg_mode", 32'd0, 32'(gg_mode));
		run_download(8'h02, 'h4200);
		check_raddr(1'b1);
		check_equal("gg_mode", 32'd1, 32'(gg_mode));
		end_test();

		test_cheat_code();

		// Writable image mounted but empty, so no load follows
		start_test("backup_save");
		img_mounted = 1'b1;
		run_download(8'h00, N_ROM);
		img_mounted = 1'b0;
		check_equal("led_user idle", 32'd0, 32'(led_user));
		bk_save_req = 1'b1;
		@(negedge clk_sys);
		bk_save_req = 1'b0;
		serve_backup(2'b01, 1'b0);
		autosave = 1'b1;
		nvram_we = 1'b1;
		@(negedge clk_sys);
		nvram_we = 1'b0;
		@(negedge clk_sys);
		check_equal("led_user with pending save", 32'd1, 32'(led_user));
		osd_open = 1'b1;
		@(negedge clk_sys);
		serve_backup(2'b01, 1'b0);
		check_equal("led_user after autosave", 32'd0, 32'(led_user));
		osd_open = 1'b0;
		autosave = 1'b0;
		end_test();

		start_test("backup_autoload");
		img_mounted = 1'b1;
		img_size_nonzero = 1'b1;
		run_download(8'h00, N_ROM);
		img_mounted = 1'b0;
		serve_backup(2'b10, 1'b1);
		end_test();

		$display("Tests run %0d, passed %0d, failed %0d", tests_run,
			tests_run - tests_failed, tests_failed);
		if (tests_failed == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sms_loader_patterns.txt
// One hex word per line, in order: 8 cartridge ROM bytes, 16 cheat bytes by offset,
// then the expected cheat flags, address, compare and replace words
// Cartridge ROM bytes
F3
ED
56
31
F0
DF
C3
00
// Cheat bytes, offsets 0 to 15
01
00
00
80
0F
C2
01
00
3C
7E
00
00
C9
18
AB
00
// Expected flags, address, compare, replace
80000001
0001C20F
00007E3C
00AB18C9

//--- sms_loader.f
+incdir+.
sms_load_pkg.sv
sms_backup_pkg.sv
clock_enables.sv
cart_download.sv
cheat_code_loader.sv
backup_sequencer.sv
sms_loader_top.sv
tb_sms_loader.sv

//--- run_sim.sh
#!/bin/sh
# Builds the loader testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
	--top-module tb_sms_loader \
	-f sms_loader.f \
	-o sim_sms_loader; then
	echo "Verilator build failed"
	exit 1
fi

if ! sim_out=$(./obj_dir/sim_sms_loader 2>&1); then
	printf '%s\n' "$sim_out"
	echo "Simulation exited with an error status"
	exit 1
fi

printf '%s\n' "$sim_out"

# Result comes from the testbench report only
if printf '%s\n' "$sim_out" | grep -qx 'ALL TESTS PASSED'; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi
